/* files.f */
verilog/kbd_pkg.sv
verilog/kbd_ifs.sv
verilog/ps2_receiver.sv
verilog/scan_ascii_rom.sv
verilog/key_tracker.sv
verilog/seg_display.sv
verilog/kbd_display_top.sv
tests/kbd_display_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module kbd_display_tb \
    -Mdir obj_dir -o kbd_display_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/kbd_display_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

/* tests/kbd_display_tb.sv */
`timescale 1ns/1ps

module kbd_display_tb import kbd_pkg::*;
();

    localparam int half_period = 20;
    localparam int wrap_pairs  = 101;

    logic       clk;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_dat;
    logic [7:0] seg1;
    logic [7:0] seg2;
    logic [7:0] seg3;
    logic [7:0] seg4;
    logic [7:0] seg5;
    logic [7:0] seg6;

    int checks       = 0;
    int value_errors = 0;
    int other_errors = 0;
    int limit_cycles = 0;

    // Reference model state.
    scan_t  m_code   = '0;
    logic   m_held   = 1'b0;
    logic   m_prefix = 1'b0;
    count_t m_count  = '0;

    kbd_display_top dut0
    (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg1    (seg1),
        .seg2    (seg2),
        .seg3    (seg3),
        .seg4    (seg4),
        .seg5    (seg5),
        .seg6    (seg6)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_seg(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp)
        begin
            value_errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_code(input string name, input scan_t got, input scan_t exp);
        checks++;
        if (got !== exp)
        begin
            value_errors++;
            $display("[FAIL] %s: model %h, file %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        checks++;
        if (got !== exp)
        begin
            value_errors++;
            $display("[FAIL] %s: model %h, file %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            value_errors++;
            $display("[FAIL] %s: model %h, file %h", name, got, exp);
        end
    endtask

    // Expected segments from the decoded fields.
    task automatic check_display(input scan_t code, input ascii_t ascii, input logic held,
                                 input count_t count);
        check_seg("seg1", seg1, held ? seg_font(code[3:0]) : seg_blank);
        check_seg("seg2", seg2, held ? seg_font(code[7:4]) : seg_blank);
        check_seg("seg3", seg3, held ? seg_font(4'(ascii % 10)) : seg_blank);
        check_seg("seg4", seg4, held ? seg_font(4'(ascii / 10)) : seg_blank);
        check_seg("seg5", seg5, seg_font(4'(count % 10)));
        check_seg("seg6", seg6, seg_font(4'(count / 10)));
    endtask

    // Make/break rules applied to frames that pass the parity check.
    task automatic model_byte(input scan_t b);
        if (m_prefix)
        begin
            m_prefix = 1'b0;
            m_held   = 1'b0;
            m_count  = count_t'((int'(m_count) + 1) % count_wrap);
        end
        else if (b == break_prefix)
            m_prefix = 1'b1;
        else
        begin
            m_code = b;
            m_held = 1'b1;
        end
    endtask

    // Start, data LSB first, odd parity, stop.
    // Data changes while ps2_clk is high.
    task automatic send_frame(input scan_t b, input logic bad);
        logic [10:0] bits;
        bits = {1'b1, ~(^b) ^ bad, b, 1'b0};
        for (int i = 0; i < 11; i++)
        begin
            ps2_dat = bits[i];
            wait_cycles(half_period);
            ps2_clk = 1'b0;
            wait_cycles(half_period);
            ps2_clk = 1'b1;
        end
        if (!bad)
            model_byte(b);
        wait_cycles(20);
    endtask

    initial
    begin
        int     fd;
        int     n;
        int     line_no;
        int     f_byte;
        int     f_bad;
        int     f_code;
        int     f_ascii;
        int     f_held;
        int     f_count;
        string  line;
        scan_t  v_byte[$];
        logic   v_bad[$];
        scan_t  v_code[$];
        ascii_t v_ascii[$];
        logic   v_held[$];
        count_t v_count[$];

        rst     = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        line_no = 0;

        fd = $fopen("tests/kbd_display_tests.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("Could not open tests/kbd_display_tests.txt");
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                line_no++;
                if (line.len() <= 1 || line.getc(0) == "#")
                    continue;
                n = $sscanf(line, "%h %d %h %d %d %d",
                            f_byte, f_bad, f_code, f_ascii, f_held, f_count);
                if (n != 6)
                begin
                    other_errors++;
                    $display("Parse error on line %0d of the test file", line_no);
                    continue;
                end
                v_byte.push_back(scan_t'(f_byte));
                v_bad.push_back(f_bad != 0);
                v_code.push_back(scan_t'(f_code));
                v_ascii.push_back(ascii_t'(f_ascii));
                v_held.push_back(f_held != 0);
                v_count.push_back(count_t'(f_count));
            end
            $fclose(fd);
            if (v_byte.size() == 0)
            begin
                other_errors++;
                $display("Test file ended before any test vector was read");
            end
        end

        limit_cycles = (v_byte.size() + 3 * wrap_pairs) * 25 * 40 + 1000;

        wait_cycles(8);
        check_display('0, '0, 1'b0, '0);
        rst = 1'b1;
        wait_cycles(1);
        check_display('0, '0, 1'b0, '0);

        foreach (v_byte[i])
        begin
            send_frame(v_byte[i], v_bad[i]);
            check_code("code", m_code, v_code[i]);
            check_flag("held", m_held, v_held[i]);
            check_count("count", m_count, v_count[i]);
            check_display(v_code[i], v_ascii[i], v_held[i], v_count[i]);
        end

        // Press and release A until the count has wrapped past 99.
        for (int p = 0; p < wrap_pairs; p++)
        begin
            send_frame(8'h1C, 1'b0);
            send_frame(break_prefix, 1'b0);
            send_frame(8'h1C, 1'b0);
            check_display(m_code, 7'd65, m_held, m_count);
        end

        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d clock cycles, the test sequence did not finish",
                 limit_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

/* tests/kbd_display_tests.txt */
# byte(hex) corrupt expected_code(hex) expected_ascii(dec) expected_held expected_count(dec)
# One PS/2 frame per line; corrupt=1 inverts the parity bit.
1C 0 1C 65 1 0
F0 0 1C 65 1 0
1C 0 1C 65 0 1
45 0 45 48 1 1
45 0 45 48 1 1
45 0 45 48 1 1
F0 0 45 48 1 1
45 0 45 48 0 2
76 0 76 0 1 2
F0 0 76 0 1 2
76 0 76 0 0 3
32 1 76 0 0 3
29 0 29 32 1 3
29 1 29 32 1 3
F0 0 29 32 1 3
29 0 29 32 0 4
1A 0 1A 90 1 4
F0 1 1A 90 1 4
F0 0 1A 90 1 4
1A 0 1A 90 0 5
16 0 16 49 1 5
3A 1 16 49 1 5
F0 0 16 49 1 5
16 0 16 49 0 6
4D 0 4D 80 1 6
F0 0 4D 80 1 6
4D 0 4D 80 0 7

/* verilog/kbd_display_top.sv */
`timescale 1ns/1ps

module kbd_display_top
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] seg1,
    output logic [7:0] seg2,
    output logic [7:0] seg3,
    output logic [7:0] seg4,
    output logic [7:0] seg5,
    output logic [7:0] seg6
);

    scan_if scan_bus ();
    key_if  key_bus ();

    ps2_receiver rx0
    (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .scan    (scan_bus.rx)
    );

    key_tracker tracker0
    (
        .clk  (clk),
        .rst  (rst),
        .scan (scan_bus.tracker),
        .key  (key_bus.tracker)
    );

    seg_display display0
    (
        .clk  (clk),
        .rst  (rst),
        .key  (key_bus.display),
        .seg1 (seg1),
        .seg2 (seg2),
        .seg3 (seg3),
        .seg4 (seg4),
        .seg5 (seg5),
        .seg6 (seg6)
    );

endmodule

/* verilog/kbd_ifs.sv */
`timescale 1ns/1ps

interface scan_if import kbd_pkg::*;
();
    scan_t code;
    logic  valid;
    logic  ready;
    logic  overflow;

    modport rx
    (
        output code,
        output valid,
        output overflow,
        input  ready
    );

    modport tracker
    (
        input  code,
        input  valid,
        input  overflow,
        output ready
    );
endinterface

interface key_if import kbd_pkg::*;
();
    scan_t  code;
    ascii_t ascii;
    logic   held;
    count_t count;

    modport tracker (output code, output ascii, output held, output count);
    modport display (input code, input ascii, input held, input count);
endinterface

/* verilog/kbd_pkg.sv */
package kbd_pkg;

    typedef logic [7:0] scan_t;
    typedef logic [6:0] ascii_t;
    typedef logic [6:0] count_t;

    // Set-2 release prefix.
    localparam scan_t break_prefix = 8'hF0;

    localparam int fifo_depth = 8;
    localparam int fifo_aw    = 3;
    localparam int count_wrap = 100;

    // Segments active low, bit 7 is the decimal point.
    localparam logic [7:0] seg_blank = 8'hFF;

    function automatic logic [7:0] seg_font(input logic [3:0] digit);
        logic [7:0] seg;
        case (digit)
            4'h0: seg = 8'hC0;
            4'h1: seg = 8'hF9;
            4'h2: seg = 8'hA4;
            4'h3: seg = 8'hB0;
            4'h4: seg = 8'h99;
            4'h5: seg = 8'h92;
            4'h6: seg = 8'h82;
            4'h7: seg = 8'hF8;
            4'h8: seg = 8'h80;
            4'h9: seg = 8'h90;
            4'hA: seg = 8'h88;
            4'hB: seg = 8'h83;
            4'hC: seg = 8'hC6;
            4'hD: seg = 8'hA1;
            4'hE: seg = 8'h86;
            default: seg = 8'h8E;
        endcase
        return seg;
    endfunction

endpackage

/* verilog/key_tracker.sv */
`timescale 1ns/1ps

module key_tracker import kbd_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    scan_if.tracker scan,
    key_if.tracker  key
);

    typedef enum logic [1:0]
    {
        idle,
        got_prefix,
        held
    } state_t;

    state_t state;
    logic   accept;
    logic   is_prefix;

    assign accept    = scan.valid && scan.ready;
    assign is_prefix = (scan.code == break_prefix);

    // Low for one cycle after every accepted byte.
    always_ff @(posedge clk)
    begin
        if (!rst)
            scan.ready <= 1'b0;
        else
            scan.ready <= !accept;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state     <= idle;
            key.code  <= '0;
            key.held  <= 1'b0;
            key.count <= '0;
        end
        else if (scan.overflow)
        begin
            // Byte stream broken, start over.
            state    <= idle;
            key.held <= 1'b0;
        end
        else if (accept)
        begin
            case (state)
                idle, held:
                    if (is_prefix)
                        state <= got_prefix;
                    else
                    begin
                        // Typematic repeat lands here too.
                        state    <= held;
                        key.code <= scan.code;
                        key.held <= 1'b1;
                    end
                got_prefix:
                begin
                    state    <= idle;
                    key.held <= 1'b0;
                    if (key.count == count_t'(count_wrap - 1))
                        key.count <= '0;
                    else
                        key.count <= key.count + 1'b1;
                end
                default:
                    state <= idle;
            endcase
        end
    end

    scan_ascii_rom rom0
    (
        .clk   (clk),
        .code  (key.code),
        .ascii (key.ascii)
    );

endmodule

/* verilog/ps2_receiver.sv */
`timescale 1ns/1ps

module ps2_receiver import kbd_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic ps2_clk,
    input  logic ps2_dat,
    scan_if.rx   scan
);

    logic [2:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_fall;
    logic [3:0] bit_cnt;
    logic [9:0] frame;
    logic       frame_done;
    logic       frame_good;

    scan_t            mem [fifo_depth];
    logic [fifo_aw:0] wr_ptr;
    logic [fifo_aw:0] rd_ptr;
    logic             fifo_full;
    logic             fifo_pop;

    // Two sync stages, third stage for edge detect.
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= 3'b111;
            dat_sync <= 2'b11;
        end
        else
        begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
        end
    end

    assign clk_fall = clk_sync[2] & ~clk_sync[1];

    // Start, eight data bits LSB first, odd parity, then stop on the last edge.
    assign frame_done = clk_fall && (bit_cnt == 4'd10);
    assign frame_good = frame_done && !frame[0] && dat_sync[1] && (^frame[9:1]);

    always_ff @(posedge clk)
    begin
        if (!rst)
            bit_cnt <= 4'd0;
        else if (frame_done)
            bit_cnt <= 4'd0;
        else if (clk_fall)
            bit_cnt <= bit_cnt + 4'd1;
    end

    always_ff @(posedge clk)
    begin
        if (clk_fall && !frame_done)
            frame[bit_cnt] <= dat_sync[1];
    end

    // Extra pointer bit tells full from empty.
    assign fifo_full = (wr_ptr[fifo_aw] != rd_ptr[fifo_aw]) &&
                       (wr_ptr[fifo_aw-1:0] == rd_ptr[fifo_aw-1:0]);
    assign fifo_pop  = scan.valid && scan.ready;

    always_ff @(posedge clk)
    begin
        if (frame_good && !fifo_full)
            mem[wr_ptr[fifo_aw-1:0]] <= frame[8:1];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            scan.overflow <= 1'b0;
        end
        else
        begin
            if (frame_good && !fifo_full)
                wr_ptr <= wr_ptr + 1'b1;
            if (fifo_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Good byte lost to a full queue.
            scan.overflow <= frame_good && fifo_full;
        end
    end

    assign scan.valid = (wr_ptr != rd_ptr);
    assign scan.code  = mem[rd_ptr[fifo_aw-1:0]];

endmodule

/* verilog/scan_ascii_rom.sv */
`timescale 1ns/1ps

module scan_ascii_rom import kbd_pkg::*;
(
    input  logic   clk,
    input  scan_t  code,
    output ascii_t ascii
);

    always_ff @(posedge clk)
    begin
        case (code)
            8'h1C: ascii <= 7'd65;
            8'h32: ascii <= 7'd66;
            8'h21: ascii <= 7'd67;
            8'h23: ascii <= 7'd68;
            8'h24: ascii <= 7'd69;
            8'h2B: ascii <= 7'd70;
            8'h34: ascii <= 7'd71;
            8'h33: ascii <= 7'd72;
            8'h43: ascii <= 7'd73;
            8'h3B: ascii <= 7'd74;
            8'h42: ascii <= 7'd75;
            8'h4B: ascii <= 7'd76;
            8'h3A: ascii <= 7'd77;
            8'h31: ascii <= 7'd78;
            8'h44: ascii <= 7'd79;
            8'h4D: ascii <= 7'd80;
            8'h15: ascii <= 7'd81;
            8'h2D: ascii <= 7'd82;
            8'h1B: ascii <= 7'd83;
            8'h2C: ascii <= 7'd84;
            8'h3C: ascii <= 7'd85;
            8'h2A: ascii <= 7'd86;
            8'h1D: ascii <= 7'd87;
            8'h22: ascii <= 7'd88;
            8'h35: ascii <= 7'd89;
            8'h1A: ascii <= 7'd90;
            // Digit row.
            8'h45: ascii <= 7'd48;
            8'h16: ascii <= 7'd49;
            8'h1E: ascii <= 7'd50;
            8'h26: ascii <= 7'd51;
            8'h25: ascii <= 7'd52;
            8'h2E: ascii <= 7'd53;
            8'h36: ascii <= 7'd54;
            8'h3D: ascii <= 7'd55;
            8'h3E: ascii <= 7'd56;
            8'h46: ascii <= 7'd57;
            8'h29: ascii <= 7'd32;
            default: ascii <= 7'd0;
        endcase
    end

endmodule

/* verilog/seg_display.sv */
`timescale 1ns/1ps

module seg_display import kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    key_if.display     key,
    output logic [7:0] seg1,
    output logic [7:0] seg2,
    output logic [7:0] seg3,
    output logic [7:0] seg4,
    output logic [7:0] seg5,
    output logic [7:0] seg6
);

    logic [3:0] ascii_ones;
    logic [3:0] ascii_tens;
    logic [3:0] count_ones;
    logic [3:0] count_tens;

    // ASCII tops out at 90, count at 99, so tens fit a nibble.
    assign ascii_ones = 4'(key.ascii % 7'd10);
    assign ascii_tens = 4'(key.ascii / 7'd10);
    assign count_ones = 4'(key.count % 7'd10);
    assign count_tens = 4'(key.count / 7'd10);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            seg1 <= seg_blank;
            seg2 <= seg_blank;
            seg3 <= seg_blank;
            seg4 <= seg_blank;
            seg5 <= seg_font(4'd0);
            seg6 <= seg_font(4'd0);
        end
        else
        begin
            if (key.held)
            begin
                seg1 <= seg_font(key.code[3:0]);
                seg2 <= seg_font(key.code[7:4]);
                seg3 <= seg_font(ascii_ones);
                seg4 <= seg_font(ascii_tens);
            end
            else
            begin
                seg1 <= seg_blank;
                seg2 <= seg_blank;
                seg3 <= seg_blank;
                seg4 <= seg_blank;
            end
            // Press count always shown.
            seg5 <= seg_font(count_ones);
            seg6 <= seg_font(count_tens);
        end
    end

endmodule
